/* alu_macros.svh */
// Data width and 3-bit command and select codes shared by every ALU source and the testbench
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// data path width in bits
`define ALU_WIDTH 32

// command codes 0 to 7
`define ADD_OP  3'd0
`define SUB_OP  3'd1
`define XOR_OP  3'd2
`define SLT_OP  3'd3
`define AND_OP  3'd4
`define NAND_OP 3'd5
`define NOR_OP  3'd6
`define OR_OP   3'd7

// result select codes for the output mux
`define SEL_ADD  3'd0
`define SEL_XOR  3'd1
`define SEL_SLT  3'd2
`define SEL_NAND 3'd3
`define SEL_NOR  3'd4

`endif

/* aluPkg.sv */
// Types shared by the ALU and its testbench; every word is ALU_WIDTH bits and codes are 3 bits
package aluPkg;

  `include "alu_macros.svh"

  typedef logic [`ALU_WIDTH-1:0] word_t;
  typedef logic [2:0]            aluCmd_t;
  typedef logic [2:0]            resultSel_t;

  // request as it arrives at the top level
  typedef struct packed {
    word_t   operandA;
    word_t   operandB;
    aluCmd_t command;
  } aluReq_t;

  // decoded control for the datapath
  typedef struct packed {
    resultSel_t sel;
    logic       invA;
    logic       invB;
  } aluCtrl_t;

  // operands after optional inversion
  typedef struct packed {
    word_t inputA;
    word_t inputB;
  } aluOperands_t;

  typedef struct packed {
    word_t sum;
    logic  carryout;
    logic  overflow;
    logic  less;
  } adderOut_t;

  typedef struct packed {
    word_t xorOut;
    word_t nandOut;
    word_t norOut;
  } logicOut_t;

  // registered response with flags
  typedef struct packed {
    word_t result;
    logic  carryout;
    logic  zero;
    logic  overflow;
  } aluResp_t;

endpackage

/* aluInputStage.sv */
// Registers a new request every cycle with no handshake and decodes it; reset decodes as add of 0
`timescale 1ns/1ps

`include "alu_macros.svh"

module aluInputStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  aluPkg::aluReq_t      req,
  output aluPkg::aluCtrl_t     ctrl,
  output aluPkg::aluOperands_t opnds
);

  import aluPkg::*;

  aluReq_t reqQ;

  // request register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      reqQ <= '0;
    end else begin
      reqQ <= req;
    end
  end

  // command decode
  always_comb begin
    ctrl = '0;
    case (reqQ.command)
      `ADD_OP: begin
        ctrl.sel  = `SEL_ADD;
        ctrl.invA = 1'b0;
        ctrl.invB = 1'b0;
      end
      // B inverted and carried in as +1
      `SUB_OP: begin
        ctrl.sel  = `SEL_ADD;
        ctrl.invA = 1'b0;
        ctrl.invB = 1'b1;
      end
      `XOR_OP: begin
        ctrl.sel  = `SEL_XOR;
        ctrl.invA = 1'b0;
        ctrl.invB = 1'b0;
      end
      // uses the subtraction of the adder
      `SLT_OP: begin
        ctrl.sel  = `SEL_SLT;
        ctrl.invA = 1'b0;
        ctrl.invB = 1'b1;
      end
      // nor of inverted operands gives and
      `AND_OP: begin
        ctrl.sel  = `SEL_NOR;
        ctrl.invA = 1'b1;
        ctrl.invB = 1'b1;
      end
      `NAND_OP: begin
        ctrl.sel  = `SEL_NAND;
        ctrl.invA = 1'b0;
        ctrl.invB = 1'b0;
      end
      `NOR_OP: begin
        ctrl.sel  = `SEL_NOR;
        ctrl.invA = 1'b0;
        ctrl.invB = 1'b0;
      end
      // nand of inverted operands gives or
      `OR_OP: begin
        ctrl.sel  = `SEL_NAND;
        ctrl.invA = 1'b1;
        ctrl.invB = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  // operand conditioning
  assign opnds.inputA = reqQ.operandA ^ {`ALU_WIDTH{ctrl.invA}};
  assign opnds.inputB = reqQ.operandB ^ {`ALU_WIDTH{ctrl.invB}};

endmodule

/* aluAdder.sv */
// Purely combinational ripple-carry adder; flags assume two's complement operands of ALU_WIDTH bits
`timescale 1ns/1ps

`include "alu_macros.svh"

module aluAdder (
  input  aluPkg::aluOperands_t opnds,
  input  logic                 invB,
  output aluPkg::adderOut_t    addOut
);

  import aluPkg::*;

  // carry chain with the carry-in at bit 0
  logic [`ALU_WIDTH:0] carry;
  word_t               sum;
  logic                overflow;

  // invB doubles as carry-in to finish the two's complement
  assign carry[0] = invB;

  // one full adder per bit
  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : gFullAdder
    logic aXorB;
    logic aAndB;

    assign aXorB      = opnds.inputA[i] ^ opnds.inputB[i];
    assign aAndB      = opnds.inputA[i] & opnds.inputB[i];
    assign sum[i]     = aXorB ^ carry[i];
    assign carry[i+1] = (aXorB & carry[i]) | aAndB;
  end

  // carry into the msb differs from carry out of it
  assign overflow = carry[`ALU_WIDTH-1] ^ carry[`ALU_WIDTH];

  assign addOut.sum      = sum;
  assign addOut.carryout = carry[`ALU_WIDTH];
  assign addOut.overflow = overflow;

  // sign of a - b corrected for overflow
  assign addOut.less = sum[`ALU_WIDTH-1] ^ overflow;

endmodule

/* aluLogicUnit.sv */
// Bitwise XOR, NAND and NOR only; AND and OR rely on the operand inversion of the input stage
`timescale 1ns/1ps

module aluLogicUnit (
  input  aluPkg::aluOperands_t opnds,
  output aluPkg::logicOut_t    logicOut
);

  import aluPkg::*;

  word_t a;
  word_t b;

  assign a = opnds.inputA;
  assign b = opnds.inputB;

  // plain xor
  assign logicOut.xorOut = a ^ b;

  // nand turns into or when both inputs come in inverted
  assign logicOut.nandOut = ~(a & b);

  // nor turns into and when both inputs come in inverted
  assign logicOut.norOut = ~(a | b);

endmodule

/* aluOutputStage.sv */
// Selects and registers the response; carryout and overflow read 0 outside the adder select
`timescale 1ns/1ps

`include "alu_macros.svh"

module aluOutputStage (
  input  logic               clk,
  input  logic               rstN,
  input  aluPkg::resultSel_t sel,
  input  aluPkg::adderOut_t  addOut,
  input  aluPkg::logicOut_t  logicOut,
  output aluPkg::aluResp_t   resp
);

  import aluPkg::*;

  word_t    sltWord;
  word_t    result;
  logic     isAdd;
  aluResp_t respD;

  // less bit zero-extended to a full word
  assign sltWord = {{(`ALU_WIDTH-1){1'b0}}, addOut.less};

  // result mux
  always_comb begin
    case (sel)
      `SEL_ADD: begin
        result = addOut.sum;
      end
      `SEL_XOR: begin
        result = logicOut.xorOut;
      end
      `SEL_SLT: begin
        result = sltWord;
      end
      `SEL_NAND: begin
        result = logicOut.nandOut;
      end
      `SEL_NOR: begin
        result = logicOut.norOut;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // flags only mean something for add and sub
  assign isAdd = (sel == `SEL_ADD);

  assign respD.result   = result;
  assign respD.carryout = isAdd & addOut.carryout;
  assign respD.overflow = isAdd & addOut.overflow;
  assign respD.zero     = (result == '0);

  // response register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      resp <= '0;
    end else begin
      resp <= respD;
    end
  end

endmodule

/* aluTop.sv */
// Two-cycle ALU with a new request taken every cycle and no handshake or valid signal
`timescale 1ns/1ps

module aluTop (
  input  logic             clk,
  input  logic             rstN,
  input  aluPkg::aluReq_t  req,
  output aluPkg::aluResp_t resp
);

  import aluPkg::*;

  aluCtrl_t     ctrl;
  aluOperands_t opnds;
  adderOut_t    addOut;
  logicOut_t    logicOut;

  // first register plus decode and inversion
  aluInputStage aluInputStage_inst (
    .clk   (clk),
    .rstN  (rstN),
    .req   (req),
    .ctrl  (ctrl),
    .opnds (opnds)
  );

  // add, sub and the less-than bit
  aluAdder aluAdder_inst (
    .opnds  (opnds),
    .invB   (ctrl.invB),
    .addOut (addOut)
  );

  // xor, nand and nor
  aluLogicUnit aluLogicUnit_inst (
    .opnds    (opnds),
    .logicOut (logicOut)
  );

  // select, flags and second register
  aluOutputStage aluOutputStage_inst (
    .clk      (clk),
    .rstN     (rstN),
    .sel      (ctrl.sel),
    .addOut   (addOut),
    .logicOut (logicOut),
    .resp     (resp)
  );

endmodule

/* aluTb.sv */
// Self-checking testbench for aluTop; assumes a fixed two-cycle latency, stops at first mismatch
`timescale 1ns/1ps

`include "alu_macros.svh"

module aluTb;

  import aluPkg::*;

  localparam int NUM_RANDOM = 2000;

  logic     clk;
  logic     rstN;
  aluReq_t  req;
  aluResp_t resp;

  // requests to apply and responses still due
  aluReq_t  stimQ[$];
  aluResp_t expQ[$];

  integer seed;
  int     numVectors = 0;
  int     compareIndex;
  bit     started;

  aluTop aluTop_inst (
    .clk  (clk),
    .rstN (rstN),
    .req  (req),
    .resp (resp)
  );

  always begin
    #5 clk = ~clk;
  end

  // expected response from plain arithmetic per command
  function automatic aluResp_t expectedResponse(input aluReq_t r);
    aluResp_t e;
    word_t    a;
    word_t    b;
    a = r.operandA;
    b = r.operandB;
    e = '0;
    case (r.command)
      `ADD_OP: begin
        e.result   = a + b;
        // wrap-around means a carry out
        e.carryout = (e.result < a);
        e.overflow = (a[`ALU_WIDTH-1] == b[`ALU_WIDTH-1]) &&
                     (e.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
      end
      `SUB_OP: begin
        e.result   = a - b;
        // carry set when no borrow
        e.carryout = (a >= b);
        e.overflow = (a[`ALU_WIDTH-1] != b[`ALU_WIDTH-1]) &&
                     (e.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
      end
      `XOR_OP:  e.result = a ^ b;
      `SLT_OP:  e.result = ($signed(a) < $signed(b)) ? 1 : 0;
      `AND_OP:  e.result = a & b;
      `NAND_OP: e.result = ~(a & b);
      `NOR_OP:  e.result = ~(a | b);
      `OR_OP:   e.result = a | b;
      default:  e.result = '0;
    endcase
    e.zero = (e.result == '0);
    return e;
  endfunction

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected 0x%h actual 0x%h (vector %0d, time %0t)",
               name, expected, actual, compareIndex, $time);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic queueRequest(input word_t a, input word_t b, input aluCmd_t cmd);
    aluReq_t r;
    r.operandA = a;
    r.operandB = b;
    r.command  = cmd;
    stimQ.push_back(r);
  endtask

  task automatic buildDirected();
    aluCmd_t logicCmds[5];
    logicCmds = '{`XOR_OP, `AND_OP, `OR_OP, `NAND_OP, `NOR_OP};
    // add with plain, carry only, overflow only and both cases
    queueRequest(32'h0000_0001, 32'h0000_0002, `ADD_OP);
    queueRequest(32'hFFFF_FFFF, 32'h0000_0001, `ADD_OP);
    queueRequest(32'h7FFF_FFFF, 32'h0000_0001, `ADD_OP);
    queueRequest(32'h8000_0000, 32'h8000_0000, `ADD_OP);
    queueRequest(32'h8000_0000, 32'hFFFF_FFFF, `ADD_OP);
    queueRequest(32'h1234_5678, 32'h0FED_CBA9, `ADD_OP);
    // sub where equal operands give zero
    queueRequest(32'h0000_0005, 32'h0000_0003, `SUB_OP);
    queueRequest(32'h0000_0003, 32'h0000_0005, `SUB_OP);
    queueRequest(32'hDEAD_BEEF, 32'hDEAD_BEEF, `SUB_OP);
    queueRequest(32'h8000_0000, 32'h0000_0001, `SUB_OP);
    queueRequest(32'h7FFF_FFFF, 32'hFFFF_FFFF, `SUB_OP);
    queueRequest(32'h0000_0000, 32'h0000_0000, `SUB_OP);
    // slt over signed pairs including overflowing subtraction
    queueRequest(32'h0000_0001, 32'h0000_0002, `SLT_OP);
    queueRequest(32'h0000_0002, 32'h0000_0001, `SLT_OP);
    queueRequest(32'hFFFF_FFFF, 32'h0000_0001, `SLT_OP);
    queueRequest(32'h0000_0001, 32'hFFFF_FFFF, `SLT_OP);
    queueRequest(32'h8000_0000, 32'h7FFF_FFFF, `SLT_OP);
    queueRequest(32'h7FFF_FFFF, 32'h8000_0000, `SLT_OP);
    queueRequest(32'h1234_5678, 32'h1234_5678, `SLT_OP);
    queueRequest(32'hFFFF_FFFB, 32'hFFFF_FFFD, `SLT_OP);
    // bitwise directed
    queueRequest(32'hA5A5_A5A5, 32'hA5A5_A5A5, `XOR_OP);
    queueRequest(32'hF0F0_F0F0, 32'h0F0F_0F0F, `XOR_OP);
    queueRequest(32'hFFFF_0000, 32'h00FF_FF00, `AND_OP);
    queueRequest(32'hFFFF_FFFF, 32'hFFFF_FFFF, `AND_OP);
    queueRequest(32'h0000_0000, 32'h0000_0000, `OR_OP);
    queueRequest(32'hAAAA_0000, 32'h0000_5555, `OR_OP);
    queueRequest(32'hFFFF_FFFF, 32'hFFFF_FFFF, `NAND_OP);
    queueRequest(32'hFF00_FF00, 32'h0FF0_0FF0, `NAND_OP);
    queueRequest(32'h0000_0000, 32'h0000_0000, `NOR_OP);
    queueRequest(32'h1357_9BDF, 32'h0246_8ACE, `NOR_OP);
    // a few random operands per bitwise command
    foreach (logicCmds[i]) begin
      repeat (4) begin
        queueRequest($random(seed), $random(seed), logicCmds[i]);
      end
    end
  endtask

  task automatic buildRandom();
    word_t a;
    word_t b;
    int    pick;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      a    = $random(seed);
      b    = $random(seed);
      pick = $random(seed);
      // equal operands now and then so the zero flag gets exercised
      if ((pick & 15) == 0) begin
        b = a;
      end
      queueRequest(a, b, aluCmd_t'(pick >> 4));
    end
  endtask

  // stimulus
  initial begin
    clk          = 1'b0;
    rstN         = 1'b0;
    req          = '0;
    seed         = 57623;
    compareIndex = 0;
    started      = 1'b0;
    buildDirected();
    buildRandom();
    numVectors = stimQ.size();
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    // both registers still hold their cleared value here
    @(negedge clk);
    checkValue("resp.result", '0, resp.result);
    checkValue("resp.carryout", '0, resp.carryout);
    checkValue("resp.zero", '0, resp.zero);
    checkValue("resp.overflow", '0, resp.overflow);
    foreach (stimQ[i]) begin
      @(posedge clk);
      req <= stimQ[i];
      expQ.push_back(expectedResponse(stimQ[i]));
      started = 1'b1;
    end
  end

  // one response compared per cycle once the pipe is full
  initial begin
    aluResp_t expected;
    wait (started);
    repeat (2) @(negedge clk);
    while (compareIndex < numVectors) begin
      @(negedge clk);
      if (expQ.size() == 0) begin
        $display("A response arrived with no expected value left to compare it with");
        $display("Simulation failed");
        $fatal(1, "expectation queue empty");
      end else begin
        expected = expQ.pop_front();
        checkValue("resp.result", expected.result, resp.result);
        checkValue("resp.carryout", expected.carryout, resp.carryout);
        checkValue("resp.zero", expected.zero, resp.zero);
        checkValue("resp.overflow", expected.overflow, resp.overflow);
        compareIndex++;
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog sized from the vector count
  initial begin
    wait (numVectors > 0);
    #((numVectors + 20) * 10);
    $display("Timeout: the run did not check all responses in the expected time");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* list.f */
+incdir+.
aluPkg.sv
aluInputStage.sv
aluAdder.sv
aluLogicUnit.sv
aluOutputStage.sv
aluTop.sv
aluTb.sv

/* Bender.yml */
package:
  name: alu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - aluPkg.sv
      - aluInputStage.sv
      - aluAdder.sv
      - aluLogicUnit.sv
      - aluOutputStage.sv
      - aluTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - aluTb.sv
